/* verilog/rv_defs.svh */
/*
 * Global sizing macros for the RV32I core.
 * Include after `timescale and before the module header in any file
 * that needs the data width, register count or reset PC.
 */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`default_nettype none

// Data path and address width
`define XLEN 32

// Architectural integer registers, x0 included
`define REG_COUNT 32

// Width of a register index field in the instruction
`define REG_IDX_W 5

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`default_nettype wire

`endif

/* verilog/rv_pkg.sv */
/*
 * Shared types for the RV32I core: opcodes, ALU operations,
 * write-back sources, access widths and the decoded control word.
 * Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

package rv_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,
        ALU_SLL    = 4'b0010,
        ALU_SLT    = 4'b0011,
        ALU_SLTU   = 4'b0100,
        ALU_XOR    = 4'b0101,
        ALU_SRL    = 4'b0110,
        ALU_SRA    = 4'b0111,
        ALU_OR     = 4'b1000,
        ALU_AND    = 4'b1001,
        ALU_PASS_B = 4'b1010  // lui
    } aluOpE;

    typedef enum logic [1:0] {
        WB_ALU   = 2'b00,
        WB_MEM   = 2'b01,  // Load data
        WB_PC4   = 2'b10,  // Link address for jal/jalr
        WB_PCIMM = 2'b11   // auipc
    } wbSelE;

    // Byte count minus one
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b11
    } accessLenE;

    typedef struct packed {
        aluOpE     aluOp;
        logic      aluSrcImm;   // Operand b from imm instead of rs2
        wbSelE     wbSel;
        logic      regWrite;
        logic      memWrite;
        logic      branch;
        logic      jump;        // jal
        logic      jumpReg;     // jalr
        accessLenE accessLen;
        logic      loadSigned;
    } ctrlT;

endpackage

`default_nettype wire

/* verilog/controller.sv */
/*
 * Instruction decoder. Classifies the opcode and turns opcode, func3
 * and func7 into the control word that steers the rest of the core.
 * Purely combinational; unknown opcodes give an all-inactive word.
 */
`timescale 1ns/1ps
`include "rv_defs.svh"
`default_nettype none

module controller
    import rv_pkg::*;
(
    input  wire logic [31:0] instr,
    output ctrlT             ctrl
);

    logic [2:0] func3;
    logic       func7b5;  // Selects SUB and SRA
    logic       immAlt;

    assign func3   = instr[14:12];
    assign func7b5 = instr[30];

    // For immediates bit 30 is part of the constant, except on srai
    assign immAlt = func7b5 && (func3 == 3'b101);

    function automatic aluOpE decodeAluOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;
        case (opcodeE'(instr[6:0]))
            OP: begin
                ctrl.aluOp    = decodeAluOp(func3, func7b5);
                ctrl.regWrite = 1'b1;
            end
            OP_IMM: begin
                ctrl.aluOp     = decodeAluOp(func3, immAlt);
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            LOAD: begin
                ctrl.aluOp      = ALU_ADD;  // Address calc
                ctrl.aluSrcImm  = 1'b1;
                ctrl.wbSel      = WB_MEM;
                ctrl.regWrite   = 1'b1;
                ctrl.accessLen  = (func3[1:0] == 2'b00) ? ACC_BYTE :
                                  (func3[1:0] == 2'b01) ? ACC_HALF : ACC_WORD;
                ctrl.loadSigned = ~func3[2];  // lbu/lhu have bit 2 set
            end
            STORE: begin
                ctrl.aluOp     = ALU_ADD;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.accessLen = (func3[1:0] == 2'b00) ? ACC_BYTE :
                                 (func3[1:0] == 2'b01) ? ACC_HALF : ACC_WORD;
            end
            BRANCH: begin
                ctrl.branch = 1'b1;  // Compare done in core
            end
            JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.wbSel    = WB_PC4;
                ctrl.regWrite = 1'b1;
            end
            JALR: begin
                ctrl.aluOp     = ALU_ADD;  // rs1 + imm is the target
                ctrl.aluSrcImm = 1'b1;
                ctrl.jumpReg   = 1'b1;
                ctrl.wbSel     = WB_PC4;
                ctrl.regWrite  = 1'b1;
            end
            LUI: begin
                ctrl.aluOp     = ALU_PASS_B;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            AUIPC: begin
                ctrl.aluOp    = ALU_ADD;
                ctrl.wbSel    = WB_PCIMM;
                ctrl.regWrite = 1'b1;
            end
            default: begin
                // No-op, PC still advances by 4
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/immGen.sv */
/*
 * Immediate generator. Picks the I, S, B, U or J layout by opcode
 * and returns the sign-extended value; zero for formats without one.
 */
`timescale 1ns/1ps
`include "rv_defs.svh"
`default_nettype none

module immGen
    import rv_pkg::*;
(
    input  wire logic [31:0]       instr,
    output logic      [`XLEN-1:0]  imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (opcodeE'(instr[6:0]))
            OP_IMM, LOAD, JALR: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            STORE: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            BRANCH: begin
                // Bit 0 always zero
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            LUI, AUIPC: begin
                imm = {instr[31:12], 12'h000};
            end
            JAL: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;  // R-type and unknown
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
/*
 * Integer ALU for the RV32I core. Add, subtract, compares, logic ops,
 * shifts by b[4:0] and a pass of operand b for lui. Combinational.
 */
`timescale 1ns/1ps
`include "rv_defs.svh"
`default_nettype none

module alu
    import rv_pkg::*;
(
    input  wire logic [`XLEN-1:0] a,
    input  wire logic [`XLEN-1:0] b,
    input  wire aluOpE            op,
    output logic      [`XLEN-1:0] result
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, ltSigned};
            ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, ltUnsigned};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);  // Keeps sign bit
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
/*
 * Integer register file: two combinational read ports, one write port
 * on the rising clock edge. x0 has no storage and always reads zero.
 * A read of the register being written returns the old value.
 */
`timescale 1ns/1ps
`include "rv_defs.svh"
`default_nettype none

module regFile (
    input  wire logic                  clk,
    input  wire logic                  rstN,
    input  wire logic [`REG_IDX_W-1:0] rs1,
    input  wire logic [`REG_IDX_W-1:0] rs2,
    input  wire logic [`REG_IDX_W-1:0] rd,
    input  wire logic                  wrEn,
    input  wire logic [`XLEN-1:0]      wrData,
    output logic      [`XLEN-1:0]      rs1Data,
    output logic      [`XLEN-1:0]      rs2Data
);

    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];  // x1..x31

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (rd != '0)) begin
            regs[rd] <= wrData;
        end
    end

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* verilog/loadStoreUnit.sv */
/*
 * Byte-lane handling for the data port. Stores replicate the byte or
 * half across the word and raise only the addressed lanes in the mask.
 * Loads shift the addressed lane down and extend by sign or zero.
 */
`timescale 1ns/1ps
`include "rv_defs.svh"
`default_nettype none

module loadStoreUnit
    import rv_pkg::*;
(
    input  wire logic [`XLEN-1:0] addr,
    input  wire logic [`XLEN-1:0] storeData,
    input  wire ctrlT             ctrl,
    input  wire logic [`XLEN-1:0] dataRdData,
    output logic      [`XLEN-1:0] dataWrData,
    output logic      [3:0]       dataWrMask,
    output logic                  dataWrEn,
    output logic      [`XLEN-1:0] loadData
);

    logic [1:0]       lane;
    logic [`XLEN-1:0] byteShifted;
    logic [`XLEN-1:0] halfShifted;
    logic             byteSign;
    logic             halfSign;

    assign lane = addr[1:0];  // Misaligned halves fall back to lane[1]

    assign dataWrEn = ctrl.memWrite;

    always_comb begin
        case (ctrl.accessLen)
            ACC_BYTE: begin
                dataWrData = {4{storeData[7:0]}};
                dataWrMask = 4'b0001 << lane;
            end
            ACC_HALF: begin
                dataWrData = {2{storeData[15:0]}};
                dataWrMask = 4'b0011 << {lane[1], 1'b0};
            end
            default: begin
                dataWrData = storeData;
                dataWrMask = 4'b1111;
            end
        endcase
    end

    // Addressed lane moved down to bit 0
    assign byteShifted = dataRdData >> {lane, 3'b000};
    assign halfShifted = dataRdData >> {lane[1], 4'b0000};

    assign byteSign = ctrl.loadSigned & byteShifted[7];
    assign halfSign = ctrl.loadSigned & halfShifted[15];

    always_comb begin
        case (ctrl.accessLen)
            ACC_BYTE: loadData = {{24{byteSign}}, byteShifted[7:0]};
            ACC_HALF: loadData = {{16{halfSign}}, halfShifted[15:0]};
            default:  loadData = dataRdData;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/core.sv */
/*
 * Single-cycle RV32I core top level. Holds the PC, resolves branches,
 * picks the next PC and write-back value, and wires up the decoder,
 * immediate generator, register file, ALU and load/store unit.
 * Fetch and data read are combinational; stores commit on the clock edge.
 */
`timescale 1ns/1ps
`include "rv_defs.svh"
`default_nettype none

module core
    import rv_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rstN,
    output logic      [`XLEN-1:0] instrAddr,
    input  wire logic [31:0]      instr,
    output logic      [`XLEN-1:0] dataAddr,
    output logic      [`XLEN-1:0] dataWrData,
    output logic      [3:0]       dataWrMask,
    output logic                  dataWrEn,
    input  wire logic [`XLEN-1:0] dataRdData
);

    ctrlT             ctrl;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcPlusImm;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] loadData;
    logic [`XLEN-1:0] wbData;
    logic             lsuWrEn;
    logic             branchCond;
    logic             branchTaken;

    controller u_controller (.instr(instr), .ctrl(ctrl));

    immGen u_immGen (.instr(instr), .imm(imm));

    regFile u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1     (instr[19:15]),
        .rs2     (instr[24:20]),
        .rd      (instr[11:7]),
        .wrEn    (ctrl.regWrite),
        .wrData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

    alu u_alu (.a(rs1Data), .b(aluB), .op(ctrl.aluOp), .result(aluResult));

    loadStoreUnit u_lsu (
        .addr       (aluResult),
        .storeData  (rs2Data),
        .ctrl       (ctrl),
        .dataRdData (dataRdData),
        .dataWrData (dataWrData),
        .dataWrMask (dataWrMask),
        .dataWrEn   (lsuWrEn),
        .loadData   (loadData)
    );

    // Branch compare by func3
    always_comb begin
        case (instr[14:12])
            3'b000:  branchCond = (rs1Data == rs2Data);                  // beq
            3'b001:  branchCond = (rs1Data != rs2Data);                  // bne
            3'b100:  branchCond = ($signed(rs1Data) < $signed(rs2Data));  // blt
            3'b101:  branchCond = ($signed(rs1Data) >= $signed(rs2Data)); // bge
            3'b110:  branchCond = (rs1Data < rs2Data);                   // bltu
            3'b111:  branchCond = (rs1Data >= rs2Data);                  // bgeu
            default: branchCond = 1'b0;
        endcase
    end

    assign branchTaken = ctrl.branch & branchCond;
    assign pcPlus4     = pc + 32'd4;
    assign pcPlusImm   = pc + imm;

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = {aluResult[`XLEN-1:1], 1'b0};  // jalr drops bit 0
        end else if (branchTaken || ctrl.jump) begin
            nextPc = pcPlusImm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    always_comb begin
        case (ctrl.wbSel)
            WB_MEM:   wbData = loadData;
            WB_PC4:   wbData = pcPlus4;
            WB_PCIMM: wbData = pcPlusImm;
            default:  wbData = aluResult;
        endcase
    end

    assign instrAddr = pc;
    assign dataAddr  = aluResult;
    assign dataWrEn  = lsuWrEn & rstN;  // No stores while the core is held in reset

endmodule

`default_nettype wire

/* verification/core_sva.sv */
/*
 * Bound assertions for the core: no stores during reset, aligned fetch
 * addresses, and store masks that fit the width given by the store's func3.
 */
`timescale 1ns/1ps
`include "rv_defs.svh"
`default_nettype none

module coreSva (
    input wire logic             clk,
    input wire logic             rstN,
    input wire logic [`XLEN-1:0] instrAddr,
    input wire logic [31:0]      instr,
    input wire logic             dataWrEn,
    input wire logic [3:0]       dataWrMask
);

    logic maskFits;

    // Access width taken from func3 of the store
    always_comb begin
        case (instr[13:12])
            2'b00:   maskFits = dataWrMask inside {4'b0001, 4'b0010, 4'b0100, 4'b1000};
            2'b01:   maskFits = dataWrMask inside {4'b0011, 4'b1100};
            default: maskFits = (dataWrMask == 4'b1111);
        endcase
    end

    noStoreInReset: assert property (@(posedge clk) !rstN |-> !dataWrEn)
        else $error("store strobe while reset is asserted");

    fetchAligned: assert property (@(posedge clk) disable iff (!rstN) instrAddr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    maskMatchesWidth: assert property (@(posedge clk) disable iff (!rstN) dataWrEn |-> maskFits)
        else $error("store mask does not fit the access width");

endmodule

bind core coreSva i_sva (
    .clk        (clk),
    .rstN       (rstN),
    .instrAddr  (instrAddr),
    .instr      (instr),
    .dataWrEn   (dataWrEn),
    .dataWrMask (dataWrMask)
);

`default_nettype wire

/* verification/core_tb.sv */
/*
 * Directed testbench for the single-cycle RV32I core. Builds small
 * programs with encoder functions, runs each from reset, and checks the
 * stores seen on the data port against a model of the instruction rules.
 */
`timescale 1ns/1ps
`include "rv_defs.svh"
`default_nettype none

module coreTb
    import rv_pkg::*;
;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_PROG     = 64;   // Longest program is the arithmetic one
    localparam int RUNS         = 9;
    localparam int WATCHDOG_NS  = RUNS * (RESET_CYCLES + MAX_PROG + 2) * PERIOD + 2000;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
    } storeT;

    logic             clk = 1'b0;
    logic             rstN = 1'b0;
    logic [`XLEN-1:0] instrAddr;
    logic [31:0]      instr;
    logic [`XLEN-1:0] dataAddr;
    logic [`XLEN-1:0] dataWrData;
    logic [3:0]       dataWrMask;
    logic             dataWrEn;
    logic [`XLEN-1:0] dataRdData;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] prog [$];
    storeT       expQ [$];
    storeT       obsQ [$];
    int          seed = 25249;
    int          errors = 0;
    int          checks = 0;

    core i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrAddr  (instrAddr),
        .instr      (instr),
        .dataAddr   (dataAddr),
        .dataWrData (dataWrData),
        .dataWrMask (dataWrMask),
        .dataWrEn   (dataWrEn),
        .dataRdData (dataRdData)
    );

    always #(PERIOD / 2) clk = ~clk;

    assign instr      = imem[instrAddr[9:2]];
    assign dataRdData = dmem[dataAddr[9:2]];

    // Data memory write by byte mask, and a log of every strobe
    always @(posedge clk) begin
        if (dataWrEn) begin
            for (int i = 0; i < 4; i++) begin
                if (dataWrMask[i]) dmem[dataAddr[9:2]][8*i +: 8] <= dataWrData[8*i +: 8];
            end
            obsQ.push_back('{dataAddr, dataWrData, dataWrMask});
        end
    end

    function automatic logic [31:0] encR(logic [31:0] f7, logic [31:0] rs2, logic [31:0] rs1,
                                         logic [31:0] f3, logic [31:0] rd, logic [6:0] op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encI(logic [31:0] imm, logic [31:0] rs1, logic [31:0] f3,
                                         logic [31:0] rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encS(logic [31:0] imm, logic [31:0] rs2, logic [31:0] rs1,
                                         logic [31:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(logic [31:0] imm, logic [31:0] rs2, logic [31:0] rs1,
                                         logic [31:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(logic [31:0] imm, logic [31:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] encU(logic [31:0] imm20, logic [31:0] rd, logic [6:0] op);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    // Reference rules for register and immediate arithmetic
    function automatic logic [31:0] aluModel(int f3, int alt, logic [31:0] a, logic [31:0] b);
        case (f3)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3: return (a < b) ? 32'd1 : 32'd0;
            4: return a ^ b;
            5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchModel(int f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            0: return a == b;
            1: return a != b;
            4: return $signed(a) < $signed(b);
            5: return $signed(a) >= $signed(b);
            6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] expandMask(logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic checkVal(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic emit(logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expectStore(logic [31:0] addr, logic [31:0] data, logic [31:0] mask);
        expQ.push_back('{addr, data, mask[3:0]});
    endtask

    // lui + addi, with the upper part rounded for the signed low part
    task automatic loadConst(int rd, logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12;
        emit(encU(upper, rd, LUI));
        emit(encI(v, rd, 0, rd, OP_IMM));
    endtask

    task automatic compareStores();
        checkVal("store count", obsQ.size(), expQ.size());
        for (int i = 0; i < obsQ.size() && i < expQ.size(); i++) begin
            checkVal("dataAddr", obsQ[i].addr, expQ[i].addr);
            checkVal("dataWrMask", {28'h0, obsQ[i].mask}, {28'h0, expQ[i].mask});
            checkVal("dataWrData", obsQ[i].data & expandMask(obsQ[i].mask),
                     expQ[i].data & expandMask(expQ[i].mask));
        end
    endtask

    // Loads the program, resets the core, runs one cycle per instruction
    task automatic runProgram();
        int n;
        n = prog.size();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[24:0], 7'b0000000};  // Opcode 0 executes as a no-op
            dmem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0203);
        end
        for (int i = 0; i < n; i++) imem[i] = prog[i];
        obsQ.delete();
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rstN = 1'b1;
        checkVal("instrAddr", instrAddr, `RESET_PC);
        repeat (n) @(posedge clk);
        #2;
        compareStores();
        prog.delete();
        expQ.delete();
    endtask

    task automatic arithTest();
        int          rf3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        int          ralt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        int          if3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
        int          ialt [9] = '{0, 0, 0, 0, 0, 0, 0, 0, 1};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] field;
        int          n;
        a = $random(seed);
        b = $random(seed);
        imm = {{20{b[11]}}, b[11:0]} ^ 32'($random(seed) & 32'hFFF);
        imm = {{20{imm[11]}}, imm[11:0]};
        n = 0;
        loadConst(1, a);
        loadConst(2, b);
        for (int k = 0; k < 10; k++) begin
            emit(encR(ralt[k] ? 32 : 0, 2, 1, rf3[k], 3, OP));
            emit(encS(32'h100 + 4 * n, 3, 0, 2));
            expectStore(32'h100 + 4 * n, aluModel(rf3[k], ralt[k], a, b), 15);
            n++;
        end
        for (int k = 0; k < 9; k++) begin
            // Shifts take shamt from the immediate, with bit 10 for srai
            field = (if3[k] == 1 || if3[k] == 5) ? {ialt[k] ? 32'h400 : 32'h0} | {27'h0, b[4:0]}
                                                  : imm;
            emit(encI(field, 1, if3[k], 3, OP_IMM));
            emit(encS(32'h100 + 4 * n, 3, 0, 2));
            expectStore(32'h100 + 4 * n,
                        aluModel(if3[k], ialt[k], a, (if3[k] == 1 || if3[k] == 5) ?
                                 {27'h0, b[4:0]} : imm), 15);
            n++;
        end
        runProgram();
    endtask

    task automatic loadStoreTest();
        logic [31:0] w;
        logic [31:0] lane;
        int          n;
        w = (32'($random(seed)) | 32'h8080_0000) & 32'hFFFF_7F7F;  // Upper bytes negative
        n = 0;
        loadConst(5, w);
        for (int k = 0; k < 4; k++) begin
            emit(encS(32'h200 + k, 5, 0, 0));
            expectStore(32'h200 + k, w << (8 * k), 1 << k);
        end
        for (int k = 0; k < 4; k += 2) begin
            emit(encS(32'h200 + k, 5, 0, 1));
            expectStore(32'h200 + k, w << (8 * k), 3 << k);
        end
        emit(encS(32'h210, 5, 0, 2));
        expectStore(32'h210, w, 15);
        for (int f3 = 0; f3 < 6; f3++) begin
            if (f3 == 3) continue;
            for (int k = 0; k < 4; k++) begin
                if ((f3 == 1 || f3 == 5) && k[0]) continue;
                if (f3 == 2 && k != 0) continue;
                lane = w >> (8 * k);
                case (f3)
                    0: lane = {{24{lane[7]}}, lane[7:0]};
                    1: lane = {{16{lane[15]}}, lane[15:0]};
                    4: lane = {24'h0, lane[7:0]};
                    5: lane = {16'h0, lane[15:0]};
                    default: lane = w;
                endcase
                emit(encI(32'h210 + k, 0, f3, 6, LOAD));
                emit(encS(32'h280 + 4 * n, 6, 0, 2));
                expectStore(32'h280 + 4 * n, lane, 15);
                n++;
            end
        end
        runProgram();
    endtask

    task automatic branchTest(logic [31:0] a, logic [31:0] b);
        int f3s [6] = '{0, 1, 4, 5, 6, 7};
        loadConst(1, a);
        loadConst(2, b);
        for (int k = 0; k < 6; k++) begin
            emit(encB(12, 2, 1, f3s[k]));
            emit(encI(1, 0, 0, 3, OP_IMM));     // Fall-through marker
            emit(encJ(8, 0));
            emit(encI(2, 0, 0, 3, OP_IMM));     // Taken marker
            emit(encS(32'h300 + 4 * k, 3, 0, 2));
            expectStore(32'h300 + 4 * k, branchModel(f3s[k], a, b) ? 2 : 1, 15);
        end
        runProgram();
    endtask

    task automatic jumpTest();
        logic [31:0] u1;
        logic [31:0] u2;
        u1 = 32'($random(seed)) & 32'hF_FFFF;
        u2 = 32'($random(seed)) & 32'hF_FFFF;
        emit(encJ(8, 1));                       // 0
        emit(encS(32'h3F0, 0, 0, 2));           // 4, skipped
        emit(encS(32'h300, 1, 0, 2));           // 8
        emit(encI(33, 0, 0, 4, OP_IMM));        // 12, odd target
        emit(encI(0, 4, 0, 5, JALR));           // 16
        repeat (3) emit(encS(32'h3F0, 0, 0, 2));
        emit(encS(32'h304, 5, 0, 2));           // 32
        emit(encU(u1, 6, AUIPC));               // 36
        emit(encS(32'h308, 6, 0, 2));
        emit(encU(u2, 7, LUI));
        emit(encS(32'h30C, 7, 0, 2));
        expectStore(32'h300, 4, 15);
        expectStore(32'h304, 20, 15);
        expectStore(32'h308, 36 + (u1 << 12), 15);
        expectStore(32'h30C, u2 << 12, 15);
        runProgram();
    endtask

    task automatic zeroRegTest();
        logic [31:0] a;
        a = $random(seed);
        emit(encS(32'h40C, 0, 0, 2));           // Store at RESET_PC, decoded all through reset
        loadConst(1, a);
        emit(encI(123, 0, 0, 0, OP_IMM));
        emit(encS(32'h400, 0, 0, 2));
        emit(encR(0, 1, 1, 0, 0, OP));
        emit(encS(32'h404, 0, 0, 2));
        emit(encR(0, 2, 2, 0, 1, 7'b0001011));  // Undefined opcode naming x1
        emit(encS(32'h408, 1, 0, 2));
        expectStore(32'h40C, 0, 15);
        expectStore(32'h400, 0, 15);
        expectStore(32'h404, 0, 15);
        expectStore(32'h408, a, 15);
        runProgram();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish in %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        for (int r = 0; r < 3; r++) arithTest();
        loadStoreTest();
        branchTest(32'd5, 32'd5);
        branchTest(32'hFFFF_FFFD, 32'd7);
        branchTest(32'd7, 32'hFFFF_FFFD);
        jumpTest();
        zeroRegTest();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
verilog/rv_pkg.sv
verilog/controller.sv
verilog/immGen.sv
verilog/alu.sv
verilog/regFile.sv
verilog/loadStoreUnit.sv
verilog/core.sv
verification/core_sva.sv
verification/core_tb.sv

/* Makefile */
# Verilator build and run for the RV32I core testbench
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
